// ==== source/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

   ////////////////////////////////////////////////////////////
   // Cache geometry
   ////////////////////////////////////////////////////////////

   // Word index inside one line
   localparam int ADDR_WIDTH      = 3;
   localparam int WORDS_PER_BLOCK = 2 ** ADDR_WIDTH;

   // Line index
   localparam int INDEX_WIDTH     = 3;
   localparam int NUM_LINES       = 2 ** INDEX_WIDTH;

   // Byte address splits as tag | index | word | byte offset
   localparam int TAG_WIDTH       = 32 - INDEX_WIDTH - ADDR_WIDTH - 2;

   ////////////////////////////////////////////////////////////
   // Vector types
   ////////////////////////////////////////////////////////////

   typedef logic [31:0]              addr_t;
   typedef logic [31:0]              word_t;
   typedef logic [3:0]               strb_t;
   typedef logic [TAG_WIDTH-1:0]     tag_t;
   typedef logic [INDEX_WIDTH-1:0]   index_t;
   typedef logic [ADDR_WIDTH-1:0]    word_idx_t;

   // 0 byte, 1 half, 2 word
   typedef logic [1:0]               size_t;

   // Controller FSM
   typedef enum logic [1:0] {
      IDLE,
      REFILL_REQ,
      REFILL,
      FINISH
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/data_cache_byte_block.sv ====
`default_nettype none

module data_cache_byte_block #(
   parameter int ADDR_WIDTH = dcache_pkg::ADDR_WIDTH
) (
   input  wire                         clk_i,
   input  wire  [ADDR_WIDTH-1:0]       addr_r_i,
   input  wire  [ADDR_WIDTH-1:0]       addr_w_i,
   input  wire  [7:0]                  data_i,
   input  wire                         write_en_i,
   output logic [7:0]                  data_o,
   input  wire  [7:0]                  flush_data_i,
   input  wire  [2**ADDR_WIDTH-1:0]    flushing_n_i
);

   // One byte of every word in the line
   logic [7:0] bytes [2**ADDR_WIDTH];

   always_ff @(posedge clk_i) begin
      for (int w = 0; w < 2**ADDR_WIDTH; w++) begin
         // Refill load wins over a byte write
         if (!flushing_n_i[w]) begin
            bytes[w] <= flush_data_i;
         end else if (write_en_i && (addr_w_i == ADDR_WIDTH'(w))) begin
            bytes[w] <= data_i;
         end
      end
   end

   // Asynchronous read port
   assign data_o = bytes[addr_r_i];

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // The controller blocks stores while a refill runs
   a_no_write_during_refill: assert property (
      @(posedge clk_i) !(write_en_i && !(&flushing_n_i))
   ) else $error("byte write collides with refill load");

endmodule

`default_nettype wire

// ==== source/data_cache_word_block.sv ====
`default_nettype none

module data_cache_word_block #(
   parameter int ADDR_WIDTH = dcache_pkg::ADDR_WIDTH
) (
   input  wire                         clk_i,
   input  wire  [ADDR_WIDTH-1:0]       addr_r_i,
   input  wire  [ADDR_WIDTH-1:0]       addr_w_i,
   input  wire  dcache_pkg::word_t     data_i,
   input  wire  dcache_pkg::strb_t     write_en_i,
   output dcache_pkg::word_t           data_o,
   input  wire  dcache_pkg::word_t     flush_data_i,
   input  wire  [2**ADDR_WIDTH-1:0]    flushing_n_i
);

   // Lane views of the word buses
   logic [7:0] lane_wdata [$bits(dcache_pkg::strb_t)];
   logic [7:0] lane_rdata [$bits(dcache_pkg::strb_t)];
   logic [7:0] lane_flush [$bits(dcache_pkg::strb_t)];

   ////////////////////////////////////////////////////////////
   // Four byte lanes, each with its own enable
   ////////////////////////////////////////////////////////////

   for (genvar i = 0; i < $bits(dcache_pkg::strb_t); i++) begin : g_lane

      assign lane_wdata[i] = data_i[8*i +: 8];
      assign lane_flush[i] = flush_data_i[8*i +: 8];

      data_cache_byte_block #(
         .ADDR_WIDTH (ADDR_WIDTH)
      ) i_byte (
         .clk_i        (clk_i),
         .addr_r_i     (addr_r_i),
         .addr_w_i     (addr_w_i),
         .data_i       (lane_wdata[i]),
         .write_en_i   (write_en_i[i]),
         .data_o       (lane_rdata[i]),
         .flush_data_i (lane_flush[i]),
         .flushing_n_i (flushing_n_i)
      );

      // Lane outputs back into one word
      assign data_o[8*i +: 8] = lane_rdata[i];

   end

endmodule

`default_nettype wire

// ==== source/data_cache_ctrl.sv ====
`default_nettype none

module data_cache_ctrl (
   input  wire                                 clk_i,
   input  wire                                 rst_n_i,
   // Core request
   input  wire                                 req_valid_i,
   input  wire                                 req_we_i,
   input  wire  dcache_pkg::addr_t             req_addr_i,
   input  wire  dcache_pkg::size_t             req_size_i,
   input  wire                                 req_signed_i,
   input  wire  dcache_pkg::word_t             req_wdata_i,
   output logic                                busy_o,
   // Memory
   output logic                                mem_rd_o,
   output logic                                mem_wr_o,
   output dcache_pkg::addr_t                   mem_addr_o,
   output dcache_pkg::word_t                   mem_wdata_o,
   output dcache_pkg::strb_t                   mem_wstrb_o,
   input  wire                                 mem_rvalid_i,
   input  wire  dcache_pkg::word_t             mem_rdata_i,
   // Line blocks
   output dcache_pkg::word_idx_t               rd_word_o,
   output dcache_pkg::word_idx_t               wr_word_o,
   output dcache_pkg::word_t                   line_wdata_o,
   output dcache_pkg::strb_t [dcache_pkg::NUM_LINES-1:0] line_we_o,
   output dcache_pkg::word_t                   flush_data_o,
   output logic [dcache_pkg::NUM_LINES-1:0][dcache_pkg::WORDS_PER_BLOCK-1:0] line_flushing_n_o,
   // Response unit
   output logic                                rsp_fire_o,
   output dcache_pkg::index_t                  rsp_line_o,
   output logic [1:0]                          rsp_byte_o,
   output dcache_pkg::size_t                   rsp_size_o,
   output logic                                rsp_signed_o
);

   dcache_pkg::ctrl_state_t          state;
   dcache_pkg::tag_t                 tags [dcache_pkg::NUM_LINES];
   logic [dcache_pkg::NUM_LINES-1:0] valid;
   dcache_pkg::word_idx_t            refill_cnt;

   // Load that missed, held until FINISH
   dcache_pkg::addr_t                miss_addr;
   dcache_pkg::size_t                miss_size;
   logic                             miss_signed;
   dcache_pkg::index_t               miss_index;
   dcache_pkg::word_idx_t            miss_word;

   dcache_pkg::tag_t                 req_tag;
   dcache_pkg::index_t               req_index;
   dcache_pkg::word_idx_t            req_word;
   logic [1:0]                       req_off;
   logic                             hit;
   logic                             load_miss;
   logic                             store;
   dcache_pkg::strb_t                req_strb;
   dcache_pkg::word_t                req_wlane;

   ////////////////////////////////////////////////////////////
   // Request decode and lookup
   ////////////////////////////////////////////////////////////

   assign req_tag   = dcache_pkg::tag_t'(req_addr_i >> (32 - dcache_pkg::TAG_WIDTH));
   assign req_index = dcache_pkg::index_t'(req_addr_i >> (dcache_pkg::ADDR_WIDTH + 2));
   assign req_word  = dcache_pkg::word_idx_t'(req_addr_i >> 2);
   assign req_off   = req_addr_i[1:0];

   assign miss_index = dcache_pkg::index_t'(miss_addr >> (dcache_pkg::ADDR_WIDTH + 2));
   assign miss_word  = dcache_pkg::word_idx_t'(miss_addr >> 2);

   assign hit       = valid[req_index] && (tags[req_index] == req_tag);
   assign load_miss = req_valid_i && !req_we_i && !hit;
   assign store     = req_valid_i && req_we_i;

   // Byte enables and lane placement of store data
   always_comb begin
      case (req_size_i)
         2'd0: begin
            req_strb  = dcache_pkg::strb_t'(4'b0001 << req_off);
            req_wlane = dcache_pkg::word_t'(req_wdata_i[7:0]) << {req_off, 3'b000};
         end
         2'd1: begin
            req_strb  = dcache_pkg::strb_t'(4'b0011 << req_off);
            req_wlane = dcache_pkg::word_t'(req_wdata_i[15:0]) << {req_off, 3'b000};
         end
         default: begin
            req_strb  = 4'b1111;
            req_wlane = req_wdata_i;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Refill FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state      <= dcache_pkg::IDLE;
         valid      <= '0;
         refill_cnt <= '0;
      end else begin
         case (state)
            dcache_pkg::IDLE: begin
               if (load_miss) begin
                  valid[req_index] <= 1'b0;
                  state            <= dcache_pkg::REFILL_REQ;
               end
            end
            dcache_pkg::REFILL_REQ: begin
               state <= dcache_pkg::REFILL;
            end
            dcache_pkg::REFILL: begin
               if (mem_rvalid_i) begin
                  refill_cnt <= refill_cnt + 1'b1;
                  // Last word of the line is in
                  if (refill_cnt == dcache_pkg::word_idx_t'(dcache_pkg::WORDS_PER_BLOCK - 1)) begin
                     valid[miss_index] <= 1'b1;
                     state             <= dcache_pkg::FINISH;
                  end
               end
            end
            default: begin
               state <= dcache_pkg::IDLE;
            end
         endcase
      end
   end

   // Tag and miss details
   always_ff @(posedge clk_i) begin
      if (state == dcache_pkg::IDLE && load_miss) begin
         tags[req_index] <= req_tag;
         miss_addr       <= req_addr_i;
         miss_size       <= req_size_i;
         miss_signed     <= req_signed_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////////////////////////

   assign busy_o   = (state != dcache_pkg::IDLE);
   assign mem_rd_o = (state == dcache_pkg::REFILL_REQ);
   assign mem_wr_o = store;

   // Line-aligned during refill request, word-aligned for stores
   assign mem_addr_o = (state == dcache_pkg::REFILL_REQ)
      ? (miss_addr & ~dcache_pkg::addr_t'(dcache_pkg::WORDS_PER_BLOCK * 4 - 1))
      : {req_addr_i[31:2], 2'b00};
   assign mem_wdata_o  = req_wlane;
   assign mem_wstrb_o  = req_strb;

   assign wr_word_o    = req_word;
   assign rd_word_o    = (state == dcache_pkg::FINISH) ? miss_word : req_word;
   assign line_wdata_o = req_wlane;
   assign flush_data_o = mem_rdata_i;

   always_comb begin
      line_we_o         = '0;
      line_flushing_n_o = '1;
      if (store && hit) begin
         line_we_o[req_index] = req_strb;
      end
      // Pull one word low per refill beat
      if (state == dcache_pkg::REFILL && mem_rvalid_i) begin
         line_flushing_n_o[miss_index][refill_cnt] = 1'b0;
      end
   end

   always_comb begin
      if (state == dcache_pkg::FINISH) begin
         rsp_fire_o   = 1'b1;
         rsp_line_o   = miss_index;
         rsp_byte_o   = miss_addr[1:0];
         rsp_size_o   = miss_size;
         rsp_signed_o = miss_signed;
      end else begin
         rsp_fire_o   = req_valid_i && !req_we_i && hit;
         rsp_line_o   = req_index;
         rsp_byte_o   = req_off;
         rsp_size_o   = req_size_i;
         rsp_signed_o = req_signed_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   a_no_req_when_busy: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) busy_o |-> !req_valid_i
   ) else $error("request strobed while busy");

   a_aligned: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) req_valid_i |->
         (req_size_i == 2'd0) ||
         (req_size_i == 2'd1 && !req_addr_i[0]) ||
         (req_size_i == 2'd2 && req_addr_i[1:0] == 2'b00)
   ) else $error("misaligned or bad-size access");

   a_rvalid_in_refill: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) mem_rvalid_i |-> state == dcache_pkg::REFILL
   ) else $error("refill word outside a refill");

endmodule

`default_nettype wire

// ==== source/data_cache_resp.sv ====
`default_nettype none

module data_cache_resp (
   input  wire                                 clk_i,
   input  wire                                 rst_n_i,
   input  wire  dcache_pkg::word_t [dcache_pkg::NUM_LINES-1:0] line_data_i,
   input  wire                                 rsp_fire_i,
   input  wire  dcache_pkg::index_t            rsp_line_i,
   input  wire  [1:0]                          rsp_byte_i,
   input  wire  dcache_pkg::size_t             rsp_size_i,
   input  wire                                 rsp_signed_i,
   output logic                                resp_valid_o,
   output dcache_pkg::word_t                   resp_data_o
);

   dcache_pkg::word_t line_word;
   dcache_pkg::word_t shifted;
   dcache_pkg::word_t ext_data;

   // Addressed word, then addressed byte or half down to bit 0
   assign line_word = line_data_i[rsp_line_i];
   assign shifted   = line_word >> {rsp_byte_i, 3'b000};

   ////////////////////////////////////////////////////////////
   // Sign or zero extension
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (rsp_size_i)
         2'd0: begin
            if (rsp_signed_i) begin
               ext_data = {{24{shifted[7]}}, shifted[7:0]};
            end else begin
               ext_data = {24'b0, shifted[7:0]};
            end
         end
         2'd1: begin
            if (rsp_signed_i) begin
               ext_data = {{16{shifted[15]}}, shifted[15:0]};
            end else begin
               ext_data = {16'b0, shifted[15:0]};
            end
         end
         default: begin
            ext_data = shifted;
         end
      endcase
   end

   // Response register, one cycle after the fire strobe
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         resp_valid_o <= 1'b0;
      end else begin
         resp_valid_o <= rsp_fire_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rsp_fire_i) begin
         resp_data_o <= ext_data;
      end
   end

endmodule

`default_nettype wire

// ==== source/data_cache_top.sv ====
`default_nettype none

module data_cache_top (
   input  wire                        clk_i,
   input  wire                        rst_n_i,
   // Core side
   input  wire                        req_valid_i,
   input  wire                        req_we_i,
   input  wire  dcache_pkg::addr_t    req_addr_i,
   input  wire  dcache_pkg::size_t    req_size_i,
   input  wire                        req_signed_i,
   input  wire  dcache_pkg::word_t    req_wdata_i,
   output logic                       busy_o,
   output logic                       resp_valid_o,
   output dcache_pkg::word_t          resp_data_o,
   // Memory side
   output logic                       mem_rd_o,
   output logic                       mem_wr_o,
   output dcache_pkg::addr_t          mem_addr_o,
   output dcache_pkg::word_t          mem_wdata_o,
   output dcache_pkg::strb_t          mem_wstrb_o,
   input  wire                        mem_rvalid_i,
   input  wire  dcache_pkg::word_t    mem_rdata_i
);

   dcache_pkg::word_idx_t                          rd_word;
   dcache_pkg::word_idx_t                          wr_word;
   dcache_pkg::word_t                              line_wdata;
   dcache_pkg::strb_t [dcache_pkg::NUM_LINES-1:0]  line_we;
   dcache_pkg::word_t                              flush_data;
   logic [dcache_pkg::NUM_LINES-1:0][dcache_pkg::WORDS_PER_BLOCK-1:0] line_flushing_n;
   dcache_pkg::word_t [dcache_pkg::NUM_LINES-1:0]  line_data;

   logic                rsp_fire;
   dcache_pkg::index_t  rsp_line;
   logic [1:0]          rsp_byte;
   dcache_pkg::size_t   rsp_size;
   logic                rsp_signed;

   ////////////////////////////////////////////////////////////
   // Controller
   ////////////////////////////////////////////////////////////

   data_cache_ctrl i_ctrl (
      .clk_i             (clk_i),
      .rst_n_i           (rst_n_i),
      .req_valid_i       (req_valid_i),
      .req_we_i          (req_we_i),
      .req_addr_i        (req_addr_i),
      .req_size_i        (req_size_i),
      .req_signed_i      (req_signed_i),
      .req_wdata_i       (req_wdata_i),
      .busy_o            (busy_o),
      .mem_rd_o          (mem_rd_o),
      .mem_wr_o          (mem_wr_o),
      .mem_addr_o        (mem_addr_o),
      .mem_wdata_o       (mem_wdata_o),
      .mem_wstrb_o       (mem_wstrb_o),
      .mem_rvalid_i      (mem_rvalid_i),
      .mem_rdata_i       (mem_rdata_i),
      .rd_word_o         (rd_word),
      .wr_word_o         (wr_word),
      .line_wdata_o      (line_wdata),
      .line_we_o         (line_we),
      .flush_data_o      (flush_data),
      .line_flushing_n_o (line_flushing_n),
      .rsp_fire_o        (rsp_fire),
      .rsp_line_o        (rsp_line),
      .rsp_byte_o        (rsp_byte),
      .rsp_size_o        (rsp_size),
      .rsp_signed_o      (rsp_signed)
   );

   // Cache lines
   for (genvar l = 0; l < dcache_pkg::NUM_LINES; l++) begin : g_line
      data_cache_word_block #(
         .ADDR_WIDTH (dcache_pkg::ADDR_WIDTH)
      ) i_line (
         .clk_i        (clk_i),
         .addr_r_i     (rd_word),
         .addr_w_i     (wr_word),
         .data_i       (line_wdata),
         .write_en_i   (line_we[l]),
         .data_o       (line_data[l]),
         .flush_data_i (flush_data),
         .flushing_n_i (line_flushing_n[l])
      );
   end

   // Load response path
   data_cache_resp i_resp (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .line_data_i  (line_data),
      .rsp_fire_i   (rsp_fire),
      .rsp_line_i   (rsp_line),
      .rsp_byte_i   (rsp_byte),
      .rsp_size_i   (rsp_size),
      .rsp_signed_i (rsp_signed),
      .resp_valid_o (resp_valid_o),
      .resp_data_o  (resp_data_o)
   );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   timeunit 1ns;
   timeprecision 100ps;

   // 4 ns period
   initial begin
      clk_o = 1'b0;
      forever #2 clk_o = ~clk_o;
   end

   // Reset held low for 8 rising edges, released just after an edge
   initial begin
      rst_n_o = 1'b0;
      repeat (8) @(posedge clk_o);
      #1;
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// ==== tests/tb_data_cache.sv ====
`default_nettype none

module tb_data_cache;

   timeunit 1ns;
   timeprecision 100ps;

   logic                clk;
   logic                rst_n;
   logic                req_valid;
   logic                req_we;
   dcache_pkg::addr_t   req_addr;
   dcache_pkg::size_t   req_size;
   logic                req_signed;
   dcache_pkg::word_t   req_wdata;
   logic                busy;
   logic                resp_valid;
   dcache_pkg::word_t   resp_data;
   logic                mem_rd;
   logic                mem_wr;
   dcache_pkg::addr_t   mem_addr;
   dcache_pkg::word_t   mem_wdata;
   dcache_pkg::strb_t   mem_wstrb;
   logic                mem_rvalid;
   dcache_pkg::word_t   mem_rdata;

   // Requests from the vector file
   logic                vec_op [$];
   dcache_pkg::addr_t   vec_addr [$];
   dcache_pkg::size_t   vec_size [$];
   logic                vec_sgn [$];
   dcache_pkg::word_t   vec_wdata [$];
   dcache_pkg::word_t   vec_exp [$];
   int                  vec_count = 0;

   // Load results still owed by the DUT in request order
   dcache_pkg::word_t   exp_q [$];

   // Words written so far by word address
   dcache_pkg::word_t   mem_words [dcache_pkg::addr_t];
   dcache_pkg::addr_t   line_addr = '0;
   integer              seed = 28173;

   // Lines the cache should hold, by index
   logic                model_valid [dcache_pkg::NUM_LINES];
   dcache_pkg::addr_t   model_line [dcache_pkg::NUM_LINES];

   tb_clock_gen i_clk_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   data_cache_top i_dut (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .req_valid_i  (req_valid),
      .req_we_i     (req_we),
      .req_addr_i   (req_addr),
      .req_size_i   (req_size),
      .req_signed_i (req_signed),
      .req_wdata_i  (req_wdata),
      .busy_o       (busy),
      .resp_valid_o (resp_valid),
      .resp_data_o  (resp_data),
      .mem_rd_o     (mem_rd),
      .mem_wr_o     (mem_wr),
      .mem_addr_o   (mem_addr),
      .mem_wdata_o  (mem_wdata),
      .mem_wstrb_o  (mem_wstrb),
      .mem_rvalid_i (mem_rvalid),
      .mem_rdata_i  (mem_rdata)
   );

   ////////////////////////////////////////////////////////////
   // Error handling and compare tasks
   ////////////////////////////////////////////////////////////

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_load(input dcache_pkg::word_t expected);
      if (resp_data !== expected) begin
         abort_run($sformatf("mismatch at %0d ns: load returned %h, expected %h",
                             $time, resp_data, expected));
      end
   endtask

   task automatic check_mem_write(input dcache_pkg::addr_t exp_addr,
                                  input dcache_pkg::word_t exp_data,
                                  input dcache_pkg::strb_t exp_strb);
      if (mem_wr !== 1'b1) begin
         abort_run("a store request produced no memory write");
      end
      if (mem_addr !== exp_addr) begin
         abort_run($sformatf("mismatch at %0d ns: write address %h, expected %h",
                             $time, mem_addr, exp_addr));
      end
      if (mem_wdata !== exp_data) begin
         abort_run($sformatf("mismatch at %0d ns: write data %h, expected %h",
                             $time, mem_wdata, exp_data));
      end
      if (mem_wstrb !== exp_strb) begin
         abort_run($sformatf("mismatch at %0d ns: write strobes %b, expected %b",
                             $time, mem_wstrb, exp_strb));
      end
   endtask

   task automatic verify_line_addr(input dcache_pkg::addr_t expected);
      if (mem_addr !== expected) begin
         abort_run($sformatf("mismatch at %0d ns: refill address %h, expected %h",
                             $time, mem_addr, expected));
      end
   endtask

   // Busy and the line read start one cycle after a missing load only
   task automatic check_refill_start(input logic exp_refill);
      if (busy !== exp_refill || mem_rd !== exp_refill) begin
         abort_run($sformatf("mismatch at %0d ns: busy_o %b mem_rd_o %b, expected %b",
                             $time, busy, mem_rd, exp_refill));
      end
   endtask

   task automatic expect_low(input logic got, input string name);
      if (got !== 1'b0) begin
         abort_run($sformatf("mismatch at %0d ns: %s is %b after reset, expected 0",
                             $time, name, got));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Memory model helpers
   ////////////////////////////////////////////////////////////

   // Unwritten words hold their word address XOR a5a5a5a5
   function automatic dcache_pkg::word_t mem_word(input dcache_pkg::addr_t byte_addr);
      dcache_pkg::addr_t wa;
      wa = byte_addr >> 2;
      if (mem_words.exists(wa)) begin
         return mem_words[wa];
      end
      return wa ^ 32'hA5A5_A5A5;
   endfunction

   task automatic apply_write(input dcache_pkg::addr_t a, input dcache_pkg::word_t d,
                              input dcache_pkg::strb_t st);
      dcache_pkg::word_t w;
      w = mem_word(a);
      for (int b = 0; b < 4; b++) begin
         if (st[b]) begin
            w[8*b +: 8] = d[8*b +: 8];
         end
      end
      mem_words[a >> 2] = w;
   endtask

   // Byte lanes a store of this size and offset lands on
   task automatic place_store(input dcache_pkg::addr_t a, input dcache_pkg::size_t s,
                              input dcache_pkg::word_t d, output dcache_pkg::strb_t st,
                              output dcache_pkg::word_t lanes);
      int off;
      int nb;
      off   = int'(a[1:0]);
      nb    = 1 << s;
      st    = '0;
      lanes = '0;
      for (int b = 0; b < 4; b++) begin
         if (b >= off && b < off + nb) begin
            st[b]            = 1'b1;
            lanes[8*b +: 8] = d[8*(b-off) +: 8];
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin : stimulus
      int                  fd;
      int                  n;
      string               line;
      int                  op_v;
      dcache_pkg::addr_t   addr_v;
      int                  size_v;
      int                  sgn_v;
      dcache_pkg::word_t   wdata_v;
      dcache_pkg::word_t   exp_v;
      dcache_pkg::strb_t   st;
      dcache_pkg::word_t   lanes;
      int                  idx;
      logic                refill;

      req_valid  = 1'b0;
      req_we     = 1'b0;
      req_addr   = '0;
      req_size   = '0;
      req_signed = 1'b0;
      req_wdata  = '0;
      for (int k = 0; k < dcache_pkg::NUM_LINES; k++) begin
         model_valid[k] = 1'b0;
      end

      fd = $fopen("tests/data_cache_vectors.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open tests/data_cache_vectors.txt");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
         end
         n = $sscanf(line, "%h %h %h %h %h %h", op_v, addr_v, size_v, sgn_v, wdata_v, exp_v);
         if (n != 6) begin
            abort_run($sformatf("unreadable line in vector file: %s", line));
         end
         vec_op.push_back(op_v != 0);
         vec_addr.push_back(addr_v);
         vec_size.push_back(dcache_pkg::size_t'(size_v));
         vec_sgn.push_back(sgn_v != 0);
         vec_wdata.push_back(wdata_v);
         vec_exp.push_back(exp_v);
      end
      $fclose(fd);
      if (vec_op.size() == 0) begin
         abort_run("the vector file holds no requests");
      end
      vec_count = vec_op.size();

      // Quiet outputs after reset
      wait (rst_n === 1'b1);
      repeat (3) begin
         @(posedge clk);
         expect_low(busy, "busy_o");
         expect_low(resp_valid, "resp_valid_o");
         expect_low(mem_rd, "mem_rd_o");
         expect_low(mem_wr, "mem_wr_o");
      end
      #1;

      for (int i = 0; i < vec_count; i++) begin
         while (busy) begin
            @(posedge clk);
            #1;
         end
         req_valid  = 1'b1;
         req_we     = vec_op[i];
         req_addr   = vec_addr[i];
         req_size   = vec_size[i];
         req_signed = vec_sgn[i];
         req_wdata  = vec_wdata[i];
         if (vec_op[i]) begin
            // Stores never allocate a line
            refill = 1'b0;
            place_store(vec_addr[i], vec_size[i], vec_wdata[i], st, lanes);
            @(posedge clk);
            check_mem_write({vec_addr[i][31:2], 2'b00}, lanes, st);
         end else begin
            // 32-byte lines, direct mapped on the line number
            line_addr        = vec_addr[i] & 32'hFFFF_FFE0;
            idx              = int'(line_addr >> 5) % dcache_pkg::NUM_LINES;
            refill           = !(model_valid[idx] && model_line[idx] == line_addr);
            model_valid[idx] = 1'b1;
            model_line[idx]  = line_addr;
            exp_q.push_back(vec_exp[i]);
            @(posedge clk);
         end
         #1;
         req_valid = 1'b0;
         req_we    = 1'b0;
         check_refill_start(refill);
      end

      // Drain the last response
      while (busy) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      if (exp_q.size() != 0) begin
         abort_run($sformatf("missing response: %0d load(s) never answered", exp_q.size()));
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Response checker
   ////////////////////////////////////////////////////////////

   initial begin : response_checker
      logic load_prev;
      load_prev = 1'b0;
      forever begin
         @(posedge clk);
         if (rst_n) begin
            if (resp_valid) begin
               if (exp_q.size() == 0) begin
                  abort_run("extra response: resp_valid_o with no load outstanding");
               end else begin
                  check_load(exp_q.pop_front());
               end
            end
            // No busy one cycle after a load means a hit
            if (load_prev && !busy && !resp_valid) begin
               abort_run("load hit was not answered one cycle after its request");
            end
            load_prev = req_valid && !req_we;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Memory model
   ////////////////////////////////////////////////////////////

   initial begin : memory_model
      dcache_pkg::addr_t base;
      int                gap;
      mem_rvalid = 1'b0;
      mem_rdata  = '0;
      forever begin
         @(posedge clk);
         if (mem_wr) begin
            if (!(req_valid && req_we)) begin
               abort_run("memory write strobed without a store request");
            end
            apply_write(mem_addr, mem_wdata, mem_wstrb);
         end
         if (mem_rd) begin
            verify_line_addr(line_addr);
            base = mem_addr;
            for (int w = 0; w < dcache_pkg::WORDS_PER_BLOCK; w++) begin
               // 0 to 3 idle cycles before each word
               gap = $random(seed) & 3;
               repeat (gap) begin
                  #1;
                  mem_rvalid = 1'b0;
                  @(posedge clk);
               end
               #1;
               mem_rvalid = 1'b1;
               mem_rdata  = mem_word(base + dcache_pkg::addr_t'(4 * w));
               @(posedge clk);
            end
            #1;
            mem_rvalid = 1'b0;
         end
      end
   end

   // Watchdog allows 60 cycles per request
   initial begin : watchdog
      wait (vec_count > 0);
      repeat (vec_count * 60) @(posedge clk);
      abort_run("timeout: the run did not finish within its cycle budget");
   end

endmodule

`default_nettype wire

// ==== tests/data_cache_vectors.txt ====
# columns, all hex: op (0 load, 1 store) addr size (0 byte, 1 half, 2 word) signed wdata expected
# expected is the load result; stores carry 0 there
0 00001000 2 0 00000000 a5a5a1a5
0 00001004 2 0 00000000 a5a5a1a4
0 00001008 2 0 00000000 a5a5a1a7
0 0000101c 2 0 00000000 a5a5a1a2
0 00001010 2 0 00000000 a5a5a1a1
0 00001040 0 1 00000000 ffffffb5
0 00001041 0 0 00000000 000000a1
0 00001042 0 1 00000000 ffffffa5
0 00001043 0 0 00000000 000000a5
0 00001040 1 1 00000000 ffffa1b5
0 00001042 1 0 00000000 0000a5a5
1 00001044 2 0 12f0807f 00000000
0 00001044 0 1 00000000 0000007f
0 00001045 0 1 00000000 ffffff80
0 00001046 0 1 00000000 fffffff0
0 00001047 0 1 00000000 00000012
0 00001044 1 1 00000000 ffff807f
0 00001046 1 1 00000000 000012f0
0 00001044 1 0 00000000 0000807f
1 00001045 0 0 000000c3 00000000
1 00001046 1 0 0000beef 00000000
0 00001044 2 0 00000000 beefc37f
1 00002008 1 0 00005a3c 00000000
0 00002008 2 0 00000000 a5a55a3c
0 0000200a 1 1 00000000 ffffa5a5
0 00001000 2 0 00000000 a5a5a1a5
0 00001100 2 0 00000000 a5a5a1e5
0 00001104 2 0 00000000 a5a5a1e4
0 00001018 2 0 00000000 a5a5a1a3
0 00001019 0 0 00000000 000000a1
0 00001047 0 1 00000000 ffffffbe
0 0000105c 2 0 00000000 a5a5a1b2
1 0000105c 0 0 00000001 00000000
0 0000105c 2 0 00000000 a5a5a101

// ==== src.f ====
source/dcache_pkg.sv
source/data_cache_byte_block.sv
source/data_cache_word_block.sv
source/data_cache_ctrl.sv
source/data_cache_resp.sv
source/data_cache_top.sv
tests/tb_clock_gen.sv
tests/tb_data_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
TOP       := tb_data_cache
FILELIST  := src.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
VECTORS   := tests/data_cache_vectors.txt

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN) $(VECTORS)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
